/* Bender.yml */
package:
  name: cekirdek

export_include_dirs:
  - src

sources:
  - src/buyruk_pkg.sv
  - src/boru_hatti_pkg.sv
  - src/getir.sv
  - src/coz_yazmacoku.sv
  - src/yurut.sv
  - src/denetim_durum_birimi.sv
  - src/cekirdek.sv
  - target: test
    files:
      - test/cekirdek_tb.sv

/* sim.f */
+incdir+src
src/buyruk_pkg.sv
src/boru_hatti_pkg.sv
src/getir.sv
src/coz_yazmacoku.sv
src/yurut.sv
src/denetim_durum_birimi.sv
src/cekirdek.sv
test/cekirdek_tb.sv

/* src/boru_hatti_pkg.sv */
// Pipeline records passed between the core stages and the hazard unit
package boru_hatti_pkg;

    import buyruk_pkg::*;

    // Fetch to decode
    typedef struct packed {
        logic [31:0] buyruk;
        logic [31:0] ps;
        logic        gecerli;
    } getir_cikis_t;

    // Decode to execute, operands already forwarded
    typedef struct packed {
        mikroislem_e mikroislem;
        logic [31:0] deger1;
        logic [31:0] deger2;
        logic [31:0] imm;
        logic [31:0] ps;
        logic [4:0]  rd;
        logic        yaz;
        logic        gecerli;
    } coz_cikis_t;

    // Register write, also used for forwarding and the trace port
    typedef struct packed {
        logic [4:0]  adres;
        logic [31:0] deger;
        logic        yaz;
    } geri_yaz_t;

    typedef enum logic [1:0] {
        YON_YAZMAC   = 2'd0,
        YON_YURUT    = 2'd1,
        YON_GERI_YAZ = 2'd2
    } yonlendir_e;

    // Taken branch or jump from execute
    typedef struct packed {
        logic        gecerli;
        logic [31:0] hedef;
    } yonlendirme_t;

endpackage

/* src/buyruk_pkg.sv */
// RV32I instruction encoding and the core's micro-operations
package buyruk_pkg;

    typedef enum logic [6:0] {
        OP_LUI   = 7'b0110111,
        OP_AUIPC = 7'b0010111,
        OP_JAL   = 7'b1101111,
        OP_JALR  = 7'b1100111,
        OP_DAL   = 7'b1100011,
        OP_IMM   = 7'b0010011,
        OP_REG   = 7'b0110011
    } opkod_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } islev3_e;

    // SUB and SRA set bit 30
    typedef enum logic [6:0] {
        F7_TEMEL = 7'b0000000,
        F7_ALT   = 7'b0100000
    } islev7_e;

    typedef enum logic [2:0] {
        DAL_BEQ  = 3'b000,
        DAL_BNE  = 3'b001,
        DAL_BLT  = 3'b100,
        DAL_BGE  = 3'b101,
        DAL_BLTU = 3'b110,
        DAL_BGEU = 3'b111
    } dallanma_e;

    // Branches sit at 5'b11xxx with the condition in the low three bits
    typedef enum logic [4:0] {
        MI_NOP = 5'd0,
        MI_ADD,
        MI_SUB,
        MI_SLL,
        MI_SLT,
        MI_SLTU,
        MI_XOR,
        MI_SRL,
        MI_SRA,
        MI_OR,
        MI_AND,
        MI_LUI,
        MI_AUIPC,
        MI_JAL,
        MI_JALR,
        MI_BEQ  = {2'b11, DAL_BEQ},
        MI_BNE  = {2'b11, DAL_BNE},
        MI_BLT  = {2'b11, DAL_BLT},
        MI_BGE  = {2'b11, DAL_BGE},
        MI_BLTU = {2'b11, DAL_BLTU},
        MI_BGEU = {2'b11, DAL_BGEU}
    } mikroislem_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        islev3_e    funct3;
        logic [4:0] rd;
        opkod_e     opkod;
    } r_bicim_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        islev3_e     funct3;
        logic [4:0]  rd;
        opkod_e      opkod;
    } i_bicim_t;

    typedef struct packed {
        logic [6:0] imm_ust;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_alt;
        opkod_e     opkod;
    } s_bicim_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        dallanma_e  kosul;
        logic [3:0] imm4_1;
        logic       imm11;
        opkod_e     opkod;
    } b_bicim_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opkod_e      opkod;
    } u_bicim_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opkod_e     opkod;
    } j_bicim_t;

    typedef union packed {
        r_bicim_t r;
        i_bicim_t i;
        s_bicim_t s;
        b_bicim_t b;
        u_bicim_t u;
        j_bicim_t j;
    } buyruk_t;

endpackage

/* src/cekirdek.sv */
// RV32I integer core top level: fetch, decode, execute and hazard unit
`timescale 1ns/1ns
`include "cekirdek_settings.svh"

module cekirdek
    import boru_hatti_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic [`CEKIRDEK_L1B_GENISLIK-1:0] l1b_buyruk_i,
    input  logic                              l1b_buyruk_gecerli_i,
    input  logic                              l1b_hazir_i,
    output logic [31:0]                       l1b_ps_o,
    output logic                              l1b_ps_gecerli_o,
    output geri_yaz_t                         geri_yaz_o
);

    getir_cikis_t gtr_getir_w;
    coz_cikis_t   cyo_coz_w;
    logic [4:0]   cyo_rs1_adres_w;
    logic [4:0]   cyo_rs2_adres_w;
    geri_yaz_t    yrt_sonuc_w;
    yonlendirme_t yrt_yonlendirme_w;
    yonlendir_e   ddb_yonlendir1_w;
    yonlendir_e   ddb_yonlendir2_w;
    logic         ddb_bosalt_w;

    getir gtr (
        .clk_i                (clk_i),
        .rst_i                (rst_i),
        .bosalt_i             (ddb_bosalt_w),
        .yonlendirme_i        (yrt_yonlendirme_w),
        .l1b_hazir_i          (l1b_hazir_i),
        .l1b_buyruk_i         (l1b_buyruk_i),
        .l1b_buyruk_gecerli_i (l1b_buyruk_gecerli_i),
        .l1b_ps_o             (l1b_ps_o),
        .l1b_ps_gecerli_o     (l1b_ps_gecerli_o),
        .getir_o              (gtr_getir_w)
    );

    coz_yazmacoku cyo (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .getir_i       (gtr_getir_w),
        .bosalt_i      (ddb_bosalt_w),
        .yonlendir1_i  (ddb_yonlendir1_w),
        .yonlendir2_i  (ddb_yonlendir2_w),
        .yurut_sonuc_i (yrt_sonuc_w),
        .geri_yaz_i    (geri_yaz_o),
        .rs1_adres_o   (cyo_rs1_adres_w),
        .rs2_adres_o   (cyo_rs2_adres_w),
        .coz_o         (cyo_coz_w)
    );

    yurut yrt (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .coz_i         (cyo_coz_w),
        .yurut_sonuc_o (yrt_sonuc_w),
        .geri_yaz_o    (geri_yaz_o),
        .yonlendirme_o (yrt_yonlendirme_w)
    );

    denetim_durum_birimi ddb (
        .rs1_adres_i   (cyo_rs1_adres_w),
        .rs2_adres_i   (cyo_rs2_adres_w),
        .yurut_sonuc_i (yrt_sonuc_w),
        .geri_yaz_i    (geri_yaz_o),
        .yonlendirme_i (yrt_yonlendirme_w),
        .yonlendir1_o  (ddb_yonlendir1_w),
        .yonlendir2_o  (ddb_yonlendir2_w),
        .bosalt_o      (ddb_bosalt_w)
    );

endmodule

/* src/cekirdek_settings.svh */
// Cekirdek core settings: reset address, register count, instruction memory width
`ifndef CEKIRDEK_SETTINGS_SVH
`define CEKIRDEK_SETTINGS_SVH

// Address of the first fetch after reset
`define CEKIRDEK_RESET_PS 32'h0000_0000

// Architectural integer registers, x0 included
`define CEKIRDEK_YAZMAC_SAYISI 32

// Instruction memory data width
`define CEKIRDEK_L1B_GENISLIK 32

`endif

/* src/coz_yazmacoku.sv */
// Decode and register read stage with operand forwarding
`timescale 1ns/1ns
`include "cekirdek_settings.svh"

module coz_yazmacoku
    import buyruk_pkg::*;
    import boru_hatti_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  getir_cikis_t getir_i,
    input  logic         bosalt_i,
    input  yonlendir_e   yonlendir1_i,
    input  yonlendir_e   yonlendir2_i,
    input  geri_yaz_t    yurut_sonuc_i,
    input  geri_yaz_t    geri_yaz_i,
    output logic [4:0]   rs1_adres_o,
    output logic [4:0]   rs2_adres_o,
    output coz_cikis_t   coz_o
);

    logic [31:0] yazmac_r [`CEKIRDEK_YAZMAC_SAYISI];

    buyruk_t     buyruk;
    mikroislem_e mikroislem;
    logic [31:0] imm;
    logic [31:0] imm_i;
    logic        yaz;
    logic        imm_kullan;
    logic        imm_gecerli;
    logic        reg_gecerli;
    coz_cikis_t  coz_d;

    function automatic mikroislem_e alu_coz(input islev3_e f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? MI_SUB : MI_ADD;
            F3_SLL:  return MI_SLL;
            F3_SLT:  return MI_SLT;
            F3_SLTU: return MI_SLTU;
            F3_XOR:  return MI_XOR;
            F3_SR:   return alt ? MI_SRA : MI_SRL;
            F3_OR:   return MI_OR;
            default: return MI_AND;
        endcase
    endfunction

    // Write-back value is visible in the same cycle
    function automatic logic [31:0] yazmac_oku(input logic [4:0] adres);
        if (adres == 5'd0) begin
            return 32'd0;
        end
        if (geri_yaz_i.yaz && geri_yaz_i.adres == adres) begin
            return geri_yaz_i.deger;
        end
        return yazmac_r[adres];
    endfunction

    function automatic logic [31:0] islenen_sec(input yonlendir_e sec, input logic [4:0] adres);
        case (sec)
            YON_YURUT:    return yurut_sonuc_i.deger;
            YON_GERI_YAZ: return geri_yaz_i.deger;
            default:      return yazmac_oku(adres);
        endcase
    endfunction

    assign buyruk      = getir_i.buyruk;
    assign rs1_adres_o = buyruk.r.rs1;
    assign rs2_adres_o = buyruk.r.rs2;
    assign imm_i       = {{20{buyruk.i.imm[11]}}, buyruk.i.imm};

    // Shift immediates keep funct7 in the upper immediate bits
    assign imm_gecerli = !(buyruk.i.funct3 inside {F3_SLL, F3_SR})
                         || buyruk.r.funct7 == F7_TEMEL
                         || (buyruk.i.funct3 == F3_SR && buyruk.r.funct7 == F7_ALT);
    assign reg_gecerli = buyruk.r.funct7 == F7_TEMEL
                         || (buyruk.r.funct7 == F7_ALT && buyruk.r.funct3 inside {F3_ADD, F3_SR});

    always_comb begin
        mikroislem = MI_NOP;
        imm        = 32'd0;
        yaz        = 1'b0;
        imm_kullan = 1'b0;
        case (buyruk.r.opkod)
            OP_LUI, OP_AUIPC: begin
                mikroislem = (buyruk.r.opkod == OP_LUI) ? MI_LUI : MI_AUIPC;
                imm        = {buyruk.u.imm, 12'd0};
                yaz        = 1'b1;
            end
            OP_JAL: begin
                mikroislem = MI_JAL;
                imm        = {{12{buyruk.j.imm20}}, buyruk.j.imm19_12, buyruk.j.imm11,
                              buyruk.j.imm10_1, 1'b0};
                yaz        = 1'b1;
            end
            OP_JALR: begin
                if (buyruk.i.funct3 == F3_ADD) begin
                    mikroislem = MI_JALR;
                    imm        = imm_i;
                    yaz        = 1'b1;
                end
            end
            OP_DAL: begin
                imm = {{20{buyruk.b.imm12}}, buyruk.b.imm11, buyruk.b.imm10_5,
                       buyruk.b.imm4_1, 1'b0};
                case (buyruk.b.kosul)
                    DAL_BEQ:  mikroislem = MI_BEQ;
                    DAL_BNE:  mikroislem = MI_BNE;
                    DAL_BLT:  mikroislem = MI_BLT;
                    DAL_BGE:  mikroislem = MI_BGE;
                    DAL_BLTU: mikroislem = MI_BLTU;
                    DAL_BGEU: mikroislem = MI_BGEU;
                    default:  mikroislem = MI_NOP;
                endcase
            end
            OP_IMM: begin
                imm        = imm_i;
                imm_kullan = 1'b1;
                if (imm_gecerli) begin
                    mikroislem = alu_coz(buyruk.i.funct3,
                                         buyruk.i.funct3 == F3_SR && buyruk.r.funct7 == F7_ALT);
                    yaz        = 1'b1;
                end
            end
            OP_REG: begin
                if (reg_gecerli) begin
                    mikroislem = alu_coz(buyruk.r.funct3, buyruk.r.funct7 == F7_ALT);
                    yaz        = 1'b1;
                end
            end
            default: begin
                // Unknown opcode retires as a no-op
                mikroislem = MI_NOP;
            end
        endcase
    end

    always_comb begin
        coz_d.mikroislem = mikroislem;
        coz_d.deger1     = islenen_sec(yonlendir1_i, buyruk.r.rs1);
        coz_d.deger2     = imm_kullan ? imm : islenen_sec(yonlendir2_i, buyruk.r.rs2);
        coz_d.imm        = imm;
        coz_d.ps         = getir_i.ps;
        coz_d.rd         = buyruk.r.rd;
        coz_d.yaz        = yaz && buyruk.r.rd != 5'd0;
        coz_d.gecerli    = getir_i.gecerli && !bosalt_i;
    end

    always_ff @(posedge clk_i) begin
        coz_o <= coz_d;
        if (rst_i) begin
            coz_o.gecerli <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (geri_yaz_i.yaz && geri_yaz_i.adres != 5'd0) begin
            yazmac_r[geri_yaz_i.adres] <= geri_yaz_i.deger;
        end
    end

    a_x0_yazilmaz: assert property (@(posedge clk_i) disable iff (rst_i)
        geri_yaz_i.yaz |-> geri_yaz_i.adres != 5'd0);

endmodule

/* src/denetim_durum_birimi.sv */
// Hazard unit producing operand forwarding selects and the flush on redirect
`timescale 1ns/1ns

module denetim_durum_birimi
    import boru_hatti_pkg::*;
(
    input  logic [4:0]   rs1_adres_i,
    input  logic [4:0]   rs2_adres_i,
    input  geri_yaz_t    yurut_sonuc_i,
    input  geri_yaz_t    geri_yaz_i,
    input  yonlendirme_t yonlendirme_i,
    output yonlendir_e   yonlendir1_o,
    output yonlendir_e   yonlendir2_o,
    output logic         bosalt_o
);

    // Youngest producer wins and x0 always comes from the register file
    function automatic yonlendir_e kaynak_sec(input logic [4:0] adres, input geri_yaz_t yurut,
                                              input geri_yaz_t geri);
        if (adres == 5'd0) begin
            return YON_YAZMAC;
        end
        if (yurut.yaz && yurut.adres == adres) begin
            return YON_YURUT;
        end
        if (geri.yaz && geri.adres == adres) begin
            return YON_GERI_YAZ;
        end
        return YON_YAZMAC;
    endfunction

    assign yonlendir1_o = kaynak_sec(rs1_adres_i, yurut_sonuc_i, geri_yaz_i);
    assign yonlendir2_o = kaynak_sec(rs2_adres_i, yurut_sonuc_i, geri_yaz_i);

    // Kills the fetch and decode registers in the redirect cycle
    assign bosalt_o = yonlendirme_i.gecerli;

endmodule

/* src/getir.sv */
// Fetch stage: program counter and instruction memory request/response handling
`timescale 1ns/1ns
`include "cekirdek_settings.svh"

module getir
    import boru_hatti_pkg::*;
(
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              bosalt_i,
    input  yonlendirme_t                      yonlendirme_i,
    input  logic                              l1b_hazir_i,
    input  logic [`CEKIRDEK_L1B_GENISLIK-1:0] l1b_buyruk_i,
    input  logic                              l1b_buyruk_gecerli_i,
    output logic [31:0]                       l1b_ps_o,
    output logic                              l1b_ps_gecerli_o,
    output getir_cikis_t                      getir_o
);

    logic [31:0] ps_r;
    logic [31:0] hedef_r;
    logic        istek_r;
    logic        bekliyor_r;
    logic        at_r;
    logic        kabul;
    logic        bos;

    assign kabul = istek_r && l1b_hazir_i;
    // Nothing requested and nothing in flight
    assign bos   = !istek_r && !bekliyor_r;

    assign l1b_ps_o         = ps_r;
    assign l1b_ps_gecerli_o = istek_r;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ps_r       <= `CEKIRDEK_RESET_PS;
            istek_r    <= 1'b0;
            bekliyor_r <= 1'b0;
            at_r       <= 1'b0;
        end else begin
            if (kabul) begin
                istek_r    <= 1'b0;
                bekliyor_r <= 1'b1;
            end
            if (l1b_buyruk_gecerli_i) begin
                bekliyor_r <= 1'b0;
                istek_r    <= 1'b1;
                at_r       <= 1'b0;
                ps_r       <= at_r ? hedef_r : ps_r + 32'd4;
            end else if (bos) begin
                istek_r <= 1'b1;
            end
            // Redirect with a request in flight waits for its response
            if (yonlendirme_i.gecerli) begin
                if (l1b_buyruk_gecerli_i || bos) begin
                    ps_r <= yonlendirme_i.hedef;
                end else begin
                    at_r <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (yonlendirme_i.gecerli) begin
            hedef_r <= yonlendirme_i.hedef;
        end
    end

    always_ff @(posedge clk_i) begin
        getir_o.buyruk <= l1b_buyruk_i;
        getir_o.ps     <= ps_r;
        if (rst_i) begin
            getir_o.gecerli <= 1'b0;
        end else begin
            getir_o.gecerli <= l1b_buyruk_gecerli_i && !at_r && !bosalt_i;
        end
    end

    a_ps_sabit: assert property (@(posedge clk_i) disable iff (rst_i)
        l1b_ps_gecerli_o && !l1b_hazir_i |=> l1b_ps_gecerli_o && $stable(l1b_ps_o));

    a_yanit_bekleniyor: assert property (@(posedge clk_i) disable iff (rst_i)
        l1b_buyruk_gecerli_i |-> bekliyor_r);

endmodule

/* src/yurut.sv */
// Execute stage: ALU, branch resolution and the write-back register
`timescale 1ns/1ns

module yurut
    import buyruk_pkg::*;
    import boru_hatti_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  coz_cikis_t   coz_i,
    output geri_yaz_t    yurut_sonuc_o,
    output geri_yaz_t    geri_yaz_o,
    output yonlendirme_t yonlendirme_o
);

    logic [31:0] sonuc;
    logic [31:0] ps_artmis;
    logic [31:0] jalr_toplam;
    logic        dal_mi;
    logic        atla;
    dallanma_e   kosul;

    function automatic logic kosul_sagla(input dallanma_e k, input logic [31:0] x,
                                         input logic [31:0] y);
        case (k)
            DAL_BEQ:  return x == y;
            DAL_BNE:  return x != y;
            DAL_BLT:  return $signed(x) < $signed(y);
            DAL_BGE:  return $signed(x) >= $signed(y);
            DAL_BLTU: return x < y;
            default:  return x >= y;
        endcase
    endfunction

    assign ps_artmis   = coz_i.ps + 32'd4;
    assign jalr_toplam = coz_i.deger1 + coz_i.imm;
    assign dal_mi      = coz_i.mikroislem[4:3] == 2'b11;
    assign kosul       = dallanma_e'(coz_i.mikroislem[2:0]);

    always_comb begin
        case (coz_i.mikroislem)
            MI_ADD:   sonuc = coz_i.deger1 + coz_i.deger2;
            MI_SUB:   sonuc = coz_i.deger1 - coz_i.deger2;
            MI_SLL:   sonuc = coz_i.deger1 << coz_i.deger2[4:0];
            MI_SLT:   sonuc = {31'd0, $signed(coz_i.deger1) < $signed(coz_i.deger2)};
            MI_SLTU:  sonuc = {31'd0, coz_i.deger1 < coz_i.deger2};
            MI_XOR:   sonuc = coz_i.deger1 ^ coz_i.deger2;
            MI_SRL:   sonuc = coz_i.deger1 >> coz_i.deger2[4:0];
            MI_SRA:   sonuc = $signed(coz_i.deger1) >>> coz_i.deger2[4:0];
            MI_OR:    sonuc = coz_i.deger1 | coz_i.deger2;
            MI_AND:   sonuc = coz_i.deger1 & coz_i.deger2;
            MI_LUI:   sonuc = coz_i.imm;
            MI_AUIPC: sonuc = coz_i.ps + coz_i.imm;
            MI_JAL,
            MI_JALR:  sonuc = ps_artmis;
            default:  sonuc = 32'd0;
        endcase
    end

    // Not-taken prediction, so only taken transfers redirect
    assign atla = coz_i.gecerli
                  && ((dal_mi && kosul_sagla(kosul, coz_i.deger1, coz_i.deger2))
                      || coz_i.mikroislem == MI_JAL
                      || coz_i.mikroislem == MI_JALR);

    assign yonlendirme_o.gecerli = atla;
    assign yonlendirme_o.hedef   = (coz_i.mikroislem == MI_JALR)
                                   ? {jalr_toplam[31:1], 1'b0}
                                   : coz_i.ps + coz_i.imm;

    assign yurut_sonuc_o.adres = coz_i.rd;
    assign yurut_sonuc_o.deger = sonuc;
    assign yurut_sonuc_o.yaz   = coz_i.gecerli && coz_i.yaz;

    always_ff @(posedge clk_i) begin
        geri_yaz_o <= yurut_sonuc_o;
        if (rst_i) begin
            geri_yaz_o.yaz <= 1'b0;
        end
    end

    a_hedef_hizali: assert property (@(posedge clk_i) disable iff (rst_i)
        yonlendirme_o.gecerli |-> yonlendirme_o.hedef[1:0] == 2'b00);

endmodule

/* test/cekirdek_tb.sv */
// Testbench for the cekirdek RV32I core with a memory model and directed program tests
`timescale 1ns/1ns
`include "cekirdek_settings.svh"

module cekirdek_tb
    import boru_hatti_pkg::*;
;

    // Run limit from tests x (reset + fetches x worst fetch cycles + drain)
    localparam int TEST_SAYISI    = 6;
    localparam int EN_COK_BUYRUK  = 70;
    localparam int EN_KOTU_ISTEK  = 12;
    localparam int SINIR          = TEST_SAYISI * (10 + EN_COK_BUYRUK * EN_KOTU_ISTEK + 60);

    localparam logic [6:0] OPI = 7'h13;
    localparam logic [6:0] OPR = 7'h33;

    logic        clk_i;
    logic        rst_i;
    logic [31:0] l1b_buyruk_i;
    logic        l1b_buyruk_gecerli_i;
    logic        l1b_hazir_i;
    logic [31:0] l1b_ps_o;
    logic        l1b_ps_gecerli_o;
    geri_yaz_t   geri_yaz_o;

    logic [31:0] bellek [256];
    logic [36:0] beklenen [$];
    logic [36:0] alinan [$];
    logic [31:0] istekler [$];
    logic [31:0] xs_durum = 32'd85;
    logic [31:0] istek_adr;
    int          konum;
    int          kalan;
    int          sayac;
    bit          rastgele;

    cekirdek u_cekirdek (
        .clk_i                (clk_i),
        .rst_i                (rst_i),
        .l1b_buyruk_i         (l1b_buyruk_i),
        .l1b_buyruk_gecerli_i (l1b_buyruk_gecerli_i),
        .l1b_hazir_i          (l1b_hazir_i),
        .l1b_ps_o             (l1b_ps_o),
        .l1b_ps_gecerli_o     (l1b_ps_gecerli_o),
        .geri_yaz_o           (geri_yaz_o)
    );

    always #50 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift();
        xs_durum = xs_durum ^ (xs_durum << 13);
        xs_durum = xs_durum ^ (xs_durum >> 17);
        xs_durum = xs_durum ^ (xs_durum << 5);
        return xs_durum;
    endfunction

    function automatic logic [31:0] bellek_oku(input logic [31:0] adr);
        logic [31:0] fark;
        fark = adr - `CEKIRDEK_RESET_PS;
        if (fark < 32'd1024) begin
            return bellek[fark[9:2]];
        end
        // Opcode zero outside the program decodes as a no-op
        return {adr[24:0] ^ {18'd0, adr[31:25]}, 7'd0};
    endfunction

    function automatic logic [31:0] r_tip(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPR};
    endfunction

    function automatic logic [31:0] i_tip(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] u_tip(input logic [19:0] imm, input int rd,
                                          input logic [6:0] op);
        return {imm, rd[4:0], op};
    endfunction

    function automatic logic [31:0] b_tip(input int off, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] j_tip(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    function automatic logic [31:0] ps_simdi();
        return `CEKIRDEK_RESET_PS + 32'(4 * konum);
    endfunction

    task automatic hata_durdur();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic program_hazirla();
        for (int i = 0; i < 256; i++) begin
            bellek[i] = bellek_oku(`CEKIRDEK_RESET_PS + 32'd1024 + 32'(4 * i));
        end
        konum = 0;
        beklenen.delete();
    endtask

    task automatic yaz(input logic [31:0] buyruk);
        bellek[konum] = buyruk;
        konum++;
    endtask

    task automatic bekle_ekle(input int rd, input logic [31:0] deger);
        beklenen.push_back({rd[4:0], deger});
    endtask

    task automatic baslat(input bit rnd);
        @(negedge clk_i);
        rst_i    = 1'b1;
        rastgele = rnd;
        repeat (10) @(negedge clk_i);
        alinan.delete();
        istekler.delete();
        rst_i = 1'b0;
    endtask

    // Waits for every expected record, then a drain window for stray writes
    task automatic izi_karsilastir(input string ad);
        while (alinan.size() < beklenen.size()) begin
            @(negedge clk_i);
        end
        repeat (30) @(negedge clk_i);
        assert (alinan.size() == beklenen.size()) else begin
            $display("ERR %0t: %s got %0d writes, expected %0d", $time, ad,
                     alinan.size(), beklenen.size());
            hata_durdur();
        end
        foreach (beklenen[i]) begin
            assert (alinan[i] == beklenen[i]) else begin
                $display("ERR %0t: %s write %0d is x%0d=%h, expected x%0d=%h", $time, ad, i,
                         alinan[i][36:32], alinan[i][31:0], beklenen[i][36:32],
                         beklenen[i][31:0]);
                hata_durdur();
            end
        end
    endtask

    task automatic alu_testi();
        logic [31:0] a;
        logic [31:0] b;
        a = 32'd100;
        b = -32'sd7;
        program_hazirla();
        yaz(i_tip(100, 0, 3'd0, 1, OPI));
        bekle_ekle(1, a);
        yaz(i_tip(-7, 0, 3'd0, 2, OPI));
        bekle_ekle(2, b);
        yaz(r_tip(7'h20, 2, 1, 3'd0, 3));
        bekle_ekle(3, a - b);
        yaz(r_tip(7'h00, 2, 1, 3'd4, 4));
        bekle_ekle(4, a ^ b);
        yaz(r_tip(7'h00, 2, 1, 3'd6, 5));
        bekle_ekle(5, a | b);
        yaz(r_tip(7'h00, 2, 1, 3'd7, 6));
        bekle_ekle(6, a & b);
        yaz(i_tip(4, 1, 3'd1, 7, OPI));
        bekle_ekle(7, a << 4);
        yaz(i_tip(1025, 2, 3'd5, 8, OPI));
        bekle_ekle(8, {b[31], b[31:1]});
        yaz(i_tip(28, 2, 3'd5, 9, OPI));
        bekle_ekle(9, b >> 28);
        yaz(r_tip(7'h00, 1, 2, 3'd2, 10));
        bekle_ekle(10, 32'd1);
        yaz(r_tip(7'h00, 1, 2, 3'd3, 11));
        bekle_ekle(11, 32'd0);
        yaz(u_tip(20'h12345, 12, 7'h37));
        bekle_ekle(12, 32'h1234_5000);
        bekle_ekle(13, ps_simdi() + 32'h1000);
        yaz(u_tip(20'h00001, 13, 7'h17));
        yaz(r_tip(7'h00, 2, 1, 3'd1, 14));
        bekle_ekle(14, a << b[4:0]);
        yaz(r_tip(7'h20, 1, 2, 3'd5, 15));
        bekle_ekle(15, $signed(b) >>> a[4:0]);
        yaz(i_tip(-1, 1, 3'd4, 16, OPI));
        bekle_ekle(16, ~a);
        yaz(i_tip(200, 1, 3'd3, 17, OPI));
        bekle_ekle(17, 32'd1);
        yaz(i_tip(-200, 1, 3'd2, 18, OPI));
        bekle_ekle(18, 32'd0);
        baslat(1'b0);
        izi_karsilastir("alu");
        // Straight-line code so every request follows the previous one
        assert (istekler[0] == `CEKIRDEK_RESET_PS) else begin
            $display("ERR %0t: first request at %h", $time, istekler[0]);
            hata_durdur();
        end
        for (int i = 1; i < istekler.size(); i++) begin
            assert (istekler[i] == istekler[i-1] + 32'd4) else begin
                $display("ERR %0t: request %0d at %h", $time, i, istekler[i]);
                hata_durdur();
            end
        end
    endtask

    task automatic zincir_testi(input bit rnd);
        program_hazirla();
        yaz(i_tip(5, 0, 3'd0, 1, OPI));
        bekle_ekle(1, 32'd5);
        yaz(i_tip(3, 1, 3'd0, 1, OPI));
        bekle_ekle(1, 32'd8);
        yaz(r_tip(7'h00, 1, 1, 3'd0, 2));
        bekle_ekle(2, 32'd16);
        yaz(r_tip(7'h20, 1, 2, 3'd0, 3));
        bekle_ekle(3, 32'd8);
        yaz(i_tip(1, 3, 3'd0, 0, OPI));
        yaz(r_tip(7'h00, 3, 0, 3'd0, 4));
        bekle_ekle(4, 32'd8);
        yaz(i_tip(2, 4, 3'd1, 5, OPI));
        bekle_ekle(5, 32'd32);
        yaz(r_tip(7'h00, 3, 5, 3'd0, 6));
        bekle_ekle(6, 32'd40);
        yaz(r_tip(7'h00, 5, 6, 3'd4, 7));
        bekle_ekle(7, 32'd8);
        yaz(r_tip(7'h00, 6, 7, 3'd6, 1));
        bekle_ekle(1, 32'd40);
        baslat(rnd);
        izi_karsilastir(rnd ? "chain random" : "chain");
    endtask

    task automatic dallanma_testi();
        // Condition, not-taken pair and taken pair with x1 = -1 and x2 = 1
        logic [2:0] f3   [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        int         nt1  [6] = '{1, 2, 2, 1, 1, 2};
        int         nt2  [6] = '{2, 2, 1, 2, 2, 1};
        int         t1   [6] = '{2, 1, 1, 2, 2, 1};
        int         t2   [6] = '{2, 2, 2, 1, 1, 2};
        int         sayim;
        program_hazirla();
        sayim = 0;
        yaz(i_tip(-1, 0, 3'd0, 1, OPI));
        bekle_ekle(1, 32'hFFFF_FFFF);
        yaz(i_tip(1, 0, 3'd0, 2, OPI));
        bekle_ekle(2, 32'd1);
        // x10 counts the increments that execute
        yaz(i_tip(0, 0, 3'd0, 10, OPI));
        bekle_ekle(10, 32'd0);
        for (int k = 0; k < 6; k++) begin
            yaz(b_tip(8, nt2[k], nt1[k], f3[k]));
            yaz(i_tip(1, 10, 3'd0, 10, OPI));
            sayim++;
            bekle_ekle(10, 32'(sayim));
            yaz(b_tip(8, t2[k], t1[k], f3[k]));
            // Skipped by the taken branch
            yaz(i_tip(1, 11, 3'd0, 11, OPI));
            yaz(i_tip(1, 10, 3'd0, 10, OPI));
            sayim++;
            bekle_ekle(10, 32'(sayim));
        end
        baslat(1'b0);
        izi_karsilastir("branch");
    endtask

    task automatic atlama_testi(input bit rnd);
        logic [31:0] taban;
        taban = `CEKIRDEK_RESET_PS;
        program_hazirla();
        yaz(j_tip(12, 1));
        bekle_ekle(1, taban + 32'd4);
        yaz(i_tip(1, 0, 3'd0, 11, OPI));
        yaz(i_tip(2, 0, 3'd0, 11, OPI));
        yaz(u_tip(20'h0, 6, 7'h17));
        bekle_ekle(6, taban + 32'd12);
        // Sum is odd and the target drops bit 0
        yaz(i_tip(21, 6, 3'd0, 7, 7'h67));
        bekle_ekle(7, taban + 32'd20);
        yaz(i_tip(3, 0, 3'd0, 11, OPI));
        yaz(i_tip(4, 0, 3'd0, 11, OPI));
        yaz(i_tip(5, 0, 3'd0, 11, OPI));
        yaz(i_tip(7, 0, 3'd0, 8, OPI));
        bekle_ekle(8, 32'd7);
        yaz(j_tip(8, 0));
        yaz(i_tip(6, 0, 3'd0, 11, OPI));
        yaz(i_tip(9, 0, 3'd0, 10, OPI));
        bekle_ekle(10, 32'd9);
        baslat(rnd);
        izi_karsilastir(rnd ? "jump random" : "jump");
    endtask

    // Instruction memory driven on the falling edge
    always @(negedge clk_i) begin
        logic hazir_yeni;
        if (rst_i) begin
            kalan                = 0;
            l1b_buyruk_gecerli_i = 1'b0;
            l1b_hazir_i          = 1'b0;
        end else begin
            l1b_buyruk_gecerli_i = 1'b0;
            if (kalan > 0) begin
                kalan = kalan - 1;
                if (kalan == 0) begin
                    l1b_buyruk_i         = bellek_oku(istek_adr);
                    l1b_buyruk_gecerli_i = 1'b1;
                end
            end
            hazir_yeni  = rastgele ? (xorshift() % 4 != 0) : 1'b1;
            l1b_hazir_i = hazir_yeni;
            // Accepted on the next rising edge
            if (l1b_ps_gecerli_o && hazir_yeni) begin
                istek_adr = l1b_ps_o;
                istekler.push_back(l1b_ps_o);
                kalan = rastgele ? 1 + int'(xorshift() % 4) : 1;
            end
        end
    end

    always @(negedge clk_i) begin
        if (!rst_i && geri_yaz_o.yaz) begin
            assert (geri_yaz_o.adres != 5'd0) else begin
                $display("ERR %0t: write to x0 on the trace", $time);
                hata_durdur();
            end
            alinan.push_back({geri_yaz_o.adres, geri_yaz_o.deger});
        end
    end

    always @(posedge clk_i) begin
        sayac++;
        if (sayac >= SINIR) begin
            $display("Timeout: the run did not finish within %0d cycles", SINIR);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        clk_i                = 1'b0;
        rst_i                = 1'b1;
        l1b_buyruk_i         = 32'd0;
        l1b_buyruk_gecerli_i = 1'b0;
        l1b_hazir_i          = 1'b0;
        rastgele             = 1'b0;
        kalan                = 0;
        sayac                = 0;
        alu_testi();
        zincir_testi(1'b0);
        dallanma_testi();
        atlama_testi(1'b0);
        zincir_testi(1'b1);
        atlama_testi(1'b1);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
